// File: dv/vec_unit_assertions.sv
// Bound into vec_unit; relies on the fixed 2-cycle latency and a synchronous active-high reset
`timescale 1ns/100ps

module vec_unit_assertions (
  input logic            clk_i,
  input logic            rst_i,
  input logic            req_valid_i,
  input vec_pkg::vop_e   req_op_i,
  // Response side of the DUT
  input logic            resp_valid_i,
  input vec_pkg::vmask_t resp_mask_i
);

  //////////////////////////////////////////////////
  // Protocol
  //////////////////////////////////////////////////

  // Every strobe comes back two edges later, never more or less
  latency_a : assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_i == $past(req_valid_i, 2))
    else $error("Response strobe does not match the request strobe two cycles earlier");

  // Reset clears the response strobe
  reset_a : assert property (@(posedge clk_i) rst_i |=> !resp_valid_i)
    else $error("Response strobe high while in reset");

  // Mask bits only for compares
  mask_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_valid_i && ($past(req_op_i, 2) != vec_pkg::VMSEQ)) |-> (resp_mask_i == '0))
    else $error("Nonzero mask on a response that was not a compare");

endmodule

bind vec_unit vec_unit_assertions i_assertions (
  .clk_i       (clk_i       ),
  .rst_i       (rst_i       ),
  .req_valid_i (req_valid_i ),
  .req_op_i    (req_op_i    ),
  .resp_valid_i(resp_valid_o),
  .resp_mask_i (resp_mask_o )
);

// File: dv/vec_unit_tb.sv
// Table cases then 40 seeded random requests back to back; responses are checked at negedge
`timescale 1ns/100ps

module vec_unit_tb;

  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 4;
  localparam int NUM_TABLE    = 8;
  localparam int NUM_RANDOM   = 40;
  localparam int ELEM_W       = $bits(vec_pkg::elem_t);
  localparam int NUM_ELEMS    = $bits(vec_pkg::vmask_t);

  logic             clk = 1'b0;
  logic             rst = 1'b1;
  logic             req_valid;
  vec_pkg::vop_e    req_op;
  vec_pkg::vec_t    req_vs1;
  vec_pkg::vec_t    req_vs2;
  logic             resp_valid;
  vec_pkg::vec_t    resp_vec;
  vec_pkg::vmask_t  resp_mask;
  vec_pkg::scalar_t resp_scalar;

  // Rising edges seen so far
  int cycle = 0;
  int vec_errors = 0;
  int mask_errors = 0;
  int scalar_errors = 0;
  int protocol_errors = 0;

  // Pending responses with the oldest at the front
  string            name_q   [$];
  int               cycle_q  [$];
  vec_pkg::vec_t    vec_q    [$];
  vec_pkg::vmask_t  mask_q   [$];
  vec_pkg::scalar_t scalar_q [$];

  //////////////////////////////////////////////////
  // Directed cases
  //////////////////////////////////////////////////

  string tbl_name [NUM_TABLE] = '{"vadd_basic", "vadd_wrap", "vand_mix", "vmseq_none",
                                  "vmseq_some", "vmseq_all", "vredsum_ff", "vredsum_mix"};
  vec_pkg::vop_e tbl_op [NUM_TABLE] = '{vec_pkg::VADD, vec_pkg::VADD, vec_pkg::VAND,
                                        vec_pkg::VMSEQ, vec_pkg::VMSEQ, vec_pkg::VMSEQ,
                                        vec_pkg::VREDSUM, vec_pkg::VREDSUM};
  vec_pkg::vec_t tbl_vs1 [NUM_TABLE] = '{32'h0403_0201, 32'hF0FF_7F01, 32'hF0F0_FF00,
                                         32'h0102_0304, 32'h1122_3344, 32'hDEAD_BEEF,
                                         32'h1234_5678, 32'hFFFF_FFFF};
  vec_pkg::vec_t tbl_vs2 [NUM_TABLE] = '{32'h1020_3040, 32'h2002_8102, 32'h3CAA_0FFF,
                                         32'h0506_0708, 32'h1199_3355, 32'hDEAD_BEEF,
                                         32'hFFFF_FFFF, 32'h0102_0304};
  // Element sums wrap at 8 bits in vadd_wrap
  vec_pkg::vec_t tbl_vec [NUM_TABLE] = '{32'h1423_3241, 32'h1001_0003, 32'h30A0_0F00,
                                         32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
  vec_pkg::vmask_t tbl_mask [NUM_TABLE] = '{4'h0, 4'h0, 4'h0, 4'h0, 4'hA, 4'hF, 4'h0, 4'h0};
  // 0x3FC is 4 x 0xFF without wrap
  vec_pkg::scalar_t tbl_scalar [NUM_TABLE] = '{16'h0, 16'h0, 16'h0, 16'h0, 16'h2, 16'h4,
                                               16'h03FC, 16'h000A};

  vec_unit dut (
    .clk_i        (clk        ),
    .rst_i        (rst        ),
    .req_valid_i  (req_valid  ),
    .req_op_i     (req_op     ),
    .req_vs1_i    (req_vs1    ),
    .req_vs2_i    (req_vs2    ),
    .resp_valid_o (resp_valid ),
    .resp_vec_o   (resp_vec   ),
    .resp_mask_o  (resp_mask  ),
    .resp_scalar_o(resp_scalar)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////

  function automatic void compute_expected(input vec_pkg::vop_e op,
                                           input vec_pkg::vec_t vs1, input vec_pkg::vec_t vs2,
                                           output vec_pkg::vec_t vec, output vec_pkg::vmask_t mask,
                                           output vec_pkg::scalar_t scalar);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    int sum;
    int hits;
    vec  = '0;
    mask = '0;
    sum  = 0;
    hits = 0;
    for (int i = 0; i < NUM_ELEMS; i++) begin
      a = vs1[i*ELEM_W +: ELEM_W];
      b = vs2[i*ELEM_W +: ELEM_W];
      // Reduction uses every vs2 element across both lanes
      sum = sum + int'(b);
      case (op)
        vec_pkg::VADD: vec[i*ELEM_W +: ELEM_W] = vec_pkg::elem_t'((int'(a) + int'(b)) % 256);
        vec_pkg::VAND: vec[i*ELEM_W +: ELEM_W] = a & b;
        vec_pkg::VMSEQ: begin
          if (a == b) begin
            mask[i] = 1'b1;
            hits    = hits + 1;
          end
        end
        default: ;
      endcase
    end
    case (op)
      vec_pkg::VMSEQ:   scalar = vec_pkg::scalar_t'(hits);
      vec_pkg::VREDSUM: scalar = vec_pkg::scalar_t'(sum);
      default:          scalar = '0;
    endcase
  endfunction

  task automatic check_vec(input string name, input vec_pkg::vec_t exp, input vec_pkg::vec_t act);
    if (act !== exp) begin
      $display("[ERROR] %s vector: expected %h, actual %h", name, exp, act);
      vec_errors++;
    end
  endtask

  task automatic check_mask(input string name, input vec_pkg::vmask_t exp,
                            input vec_pkg::vmask_t act);
    if (act !== exp) begin
      $display("[ERROR] %s mask: expected %b, actual %b", name, exp, act);
      mask_errors++;
    end
  endtask

  task automatic check_scalar(input string name, input vec_pkg::scalar_t exp,
                              input vec_pkg::scalar_t act);
    if (act !== exp) begin
      $display("[ERROR] %s scalar: expected %0d, actual %0d", name, exp, act);
      scalar_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Drives one request in the next cycle and queues its expected response
  task automatic send_request(input string name, input vec_pkg::vop_e op,
                              input vec_pkg::vec_t vs1, input vec_pkg::vec_t vs2,
                              input vec_pkg::vec_t ev, input vec_pkg::vmask_t em,
                              input vec_pkg::scalar_t es);
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_op    = op;
    req_vs1   = vs1;
    req_vs2   = vs2;
    // Sampled at the next edge and visible at the negedge two cycles on
    name_q.push_back(name);
    cycle_q.push_back(cycle + 2);
    vec_q.push_back(ev);
    mask_q.push_back(em);
    scalar_q.push_back(es);
  endtask

  task automatic send_random(input int idx);
    logic [1:0]       op_bits;
    vec_pkg::vop_e    op;
    vec_pkg::vec_t    vs1;
    vec_pkg::vec_t    vs2;
    vec_pkg::vec_t    ev;
    vec_pkg::vmask_t  em;
    vec_pkg::scalar_t es;
    op_bits = 2'($urandom_range(3, 0));
    op      = vec_pkg::vop_e'(op_bits);
    vs1     = $urandom();
    vs2     = $urandom();
    // Copy about half the elements so compares hit
    for (int i = 0; i < NUM_ELEMS; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        vs2[i*ELEM_W +: ELEM_W] = vs1[i*ELEM_W +: ELEM_W];
      end
    end
    compute_expected(op, vs1, vs2, ev, em, es);
    send_request($sformatf("random_%0d", idx), op, vs1, vs2, ev, em, es);
  endtask

  //////////////////////////////////////////////////
  // Response monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin : response_monitor
    string name;
    int    exp_cycle;
    if (resp_valid) begin
      if (name_q.size() == 0) begin
        $display("Response seen at cycle %0d with no request pending", cycle);
        protocol_errors++;
      end else begin
        name      = name_q.pop_front();
        exp_cycle = cycle_q.pop_front();
        if (cycle != exp_cycle) begin
          $display("%s answered at cycle %0d instead of %0d", name, cycle, exp_cycle);
          protocol_errors++;
        end
        check_vec(name, vec_q.pop_front(), resp_vec);
        check_mask(name, mask_q.pop_front(), resp_mask);
        check_scalar(name, scalar_q.pop_front(), resp_scalar);
      end
    end
  end

  // Budget covers reset, every request and a short drain
  initial begin : watchdog
    repeat (RESET_CYCLES) @(posedge clk);
    repeat (NUM_TABLE + NUM_RANDOM + 20) @(posedge clk);
    $display("Timeout: the run did not finish within the cycle budget");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main_sequence
    int total;
    void'($urandom(39));
    req_valid = 1'b0;
    req_op    = vec_pkg::VADD;
    req_vs1   = '0;
    req_vs2   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    // Quiet period where the monitor flags any stray response
    repeat (IDLE_CYCLES) @(posedge clk);
    for (int t = 0; t < NUM_TABLE; t++) begin
      send_request(tbl_name[t], tbl_op[t], tbl_vs1[t], tbl_vs2[t],
                   tbl_vec[t], tbl_mask[t], tbl_scalar[t]);
    end
    for (int r = 0; r < NUM_RANDOM; r++) begin
      send_random(r);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    while (name_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    total = vec_errors + mask_errors + scalar_errors + protocol_errors;
    $display("Errors: vector %0d, mask %0d, scalar %0d, protocol %0d",
             vec_errors, mask_errors, scalar_errors, protocol_errors);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+rtl
rtl/vec_pkg.sv
rtl/vec_lane.sv
rtl/vec_combine.sv
rtl/vec_unit.sv
dv/vec_unit_assertions.sv
dv/vec_unit_tb.sv

// File: rtl/vec_combine.sv
// Joins exactly two lanes with lane 0 low; outputs hold between strobes, no back-pressure
`timescale 1ns/100ps

module vec_combine (
  input  logic                clk_i,
  input  logic                rst_i,
  // Control, taken from lane 0 only
  input  logic                valid_i,
  input  vec_pkg::vop_e       op_i,
  // Lane result slices
  input  vec_pkg::lane_vec_t  lane0_res_i,
  input  vec_pkg::lane_vec_t  lane1_res_i,
  // Lane compare bits
  input  vec_pkg::lane_mask_t lane0_mask_i,
  input  vec_pkg::lane_mask_t lane1_mask_i,
  // Lane partial scalars
  input  vec_pkg::scalar_t    lane0_partial_i,
  input  vec_pkg::scalar_t    lane1_partial_i,
  // Full response
  output logic                valid_o,
  output vec_pkg::vec_t       vec_o,
  output vec_pkg::vmask_t     mask_o,
  output vec_pkg::scalar_t    scalar_o
);

  //////////////////////////////////////////////////
  // Join logic
  //////////////////////////////////////////////////

  // Lane slices side by side, lane 0 in the low half
  vec_pkg::vec_t    vec_d;
  vec_pkg::vmask_t  mask_d;
  // Sum of both partials
  // Max is 1020 for VREDSUM, well inside 16 bits
  vec_pkg::scalar_t scalar_sum;
  // Scalar only meaningful for the compare and the reduction
  logic             scalar_op;

  assign vec_d      = {lane1_res_i, lane0_res_i};
  assign mask_d     = {lane1_mask_i, lane0_mask_i};
  assign scalar_sum = lane0_partial_i + lane1_partial_i;
  assign scalar_op  = (op_i == vec_pkg::VMSEQ) || (op_i == vec_pkg::VREDSUM);

  //////////////////////////////////////////////////
  // Response registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o  <= 1'b0;
      vec_o    <= '0;
      mask_o   <= '0;
      scalar_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        vec_o  <= vec_d;
        mask_o <= mask_d;
        // Other ops write an explicit zero
        if (scalar_op) begin
          scalar_o <= scalar_sum;
        end else begin
          scalar_o <= '0;
        end
      end
    end
  end

endmodule

// File: rtl/vec_config.svh
// Sizes are fixed for two lanes of two 8-bit elements; the combiner and slicing rely on that
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

//////////////////////////////////////////////////
// Lane structure
//////////////////////////////////////////////////

// Number of parallel lanes
// vec_combine joins exactly two, so keep this at 2
`define VEC_NR_LANES 2

// Elements handled by one lane
`define VEC_ELEMS_PER_LANE 2

//////////////////////////////////////////////////
// Data widths
//////////////////////////////////////////////////

// Bits per vector element
`define VEC_ELEM_WIDTH 8

// Scalar result width
// Covers a full reduction of 4 x 0xFF = 1020 without wrap
`define VEC_SCALAR_WIDTH 16

`endif

// File: rtl/vec_lane.sv
// One lane of two elements; results appear one cycle after valid_i, no back-pressure
`timescale 1ns/100ps

`include "vec_config.svh"

module vec_lane (
  input  logic                clk_i,
  input  logic                rst_i,
  // Request slice from the top
  input  logic                valid_i,
  input  vec_pkg::vop_e       op_i,
  input  vec_pkg::lane_vec_t  vs1_i,
  input  vec_pkg::lane_vec_t  vs2_i,
  // Registered results towards the combiner
  output logic                valid_o,
  output vec_pkg::vop_e       op_o,
  output vec_pkg::lane_vec_t  res_o,
  output vec_pkg::lane_mask_t mask_o,
  output vec_pkg::scalar_t    partial_o
);

  //////////////////////////////////////////////////
  // Element datapath
  //////////////////////////////////////////////////

  vec_pkg::lane_vec_t  res_d;
  vec_pkg::lane_mask_t mask_d;
  vec_pkg::scalar_t    partial_d;
  // Running count of equal elements
  vec_pkg::scalar_t    eq_count;
  // Zero-extended sum of the vs2 slice
  vec_pkg::scalar_t    vs2_sum;

  always_comb begin : lane_alu
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    a        = '0;
    b        = '0;
    res_d    = '0;
    mask_d   = '0;
    eq_count = '0;
    vs2_sum  = '0;
    for (int i = 0; i < `VEC_ELEMS_PER_LANE; i++) begin
      a = vs1_i[i*`VEC_ELEM_WIDTH +: `VEC_ELEM_WIDTH];
      b = vs2_i[i*`VEC_ELEM_WIDTH +: `VEC_ELEM_WIDTH];
      case (op_i)
        // Sum truncated to the element, so it wraps
        vec_pkg::VADD:  res_d[i*`VEC_ELEM_WIDTH +: `VEC_ELEM_WIDTH] = a + b;
        vec_pkg::VAND:  res_d[i*`VEC_ELEM_WIDTH +: `VEC_ELEM_WIDTH] = a & b;
        vec_pkg::VMSEQ: mask_d[i] = (a == b);
        // VREDSUM leaves the vector at zero
        default: ;
      endcase
      // Mask bits only exist for VMSEQ, so this is the popcount
      if (mask_d[i]) begin
        eq_count = eq_count + vec_pkg::scalar_t'(1);
      end
      vs2_sum = vs2_sum + vec_pkg::scalar_t'(b);
    end

    // Pick the partial scalar for this op
    case (op_i)
      vec_pkg::VMSEQ:   partial_d = eq_count;
      vec_pkg::VREDSUM: partial_d = vs2_sum;
      default:          partial_d = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o   <= 1'b0;
      op_o      <= vec_pkg::VADD;
      res_o     <= '0;
      mask_o    <= '0;
      partial_o <= '0;
    end else begin
      // Strobe goes straight through
      valid_o <= valid_i;
      // Data held between requests
      if (valid_i) begin
        op_o      <= op_i;
        res_o     <= res_d;
        mask_o    <= mask_d;
        partial_o <= partial_d;
      end
    end
  end

endmodule

// File: rtl/vec_pkg.sv
// Types only; all widths follow vec_config.svh, which must be on the include path
package vec_pkg;

  `include "vec_config.svh"

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  // One element
  typedef logic [`VEC_ELEM_WIDTH-1:0] elem_t;

  // Slice owned by one lane, element 0 in the low bits
  typedef logic [`VEC_ELEMS_PER_LANE*`VEC_ELEM_WIDTH-1:0] lane_vec_t;

  // Full vector across all lanes
  typedef logic [`VEC_NR_LANES*`VEC_ELEMS_PER_LANE*`VEC_ELEM_WIDTH-1:0] vec_t;

  // One compare bit per element of a lane
  typedef logic [`VEC_ELEMS_PER_LANE-1:0] lane_mask_t;

  // Compare bits of the full vector
  typedef logic [`VEC_NR_LANES*`VEC_ELEMS_PER_LANE-1:0] vmask_t;

  // Scalar result, also used for per-lane partials
  typedef logic [`VEC_SCALAR_WIDTH-1:0] scalar_t;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    VADD    = 2'd0, // element-wise add, wraps at element width
    VAND    = 2'd1, // element-wise AND
    VMSEQ   = 2'd2, // equality compare, scalar is popcount of the mask
    VREDSUM = 2'd3  // sum of all vs2 elements
  } vop_e;

endpackage

// File: rtl/vec_unit.sv
// Fixed latency of 2 cycles, a new request each cycle allowed, no back-pressure on responses
`timescale 1ns/100ps

`include "vec_config.svh"

module vec_unit (
  input  logic             clk_i,
  input  logic             rst_i,
  // Request strobe and operands
  input  logic             req_valid_i,
  input  vec_pkg::vop_e    req_op_i,
  input  vec_pkg::vec_t    req_vs1_i,
  input  vec_pkg::vec_t    req_vs2_i,
  // Response strobe and results
  output logic             resp_valid_o,
  output vec_pkg::vec_t    resp_vec_o,
  output vec_pkg::vmask_t  resp_mask_o,
  output vec_pkg::scalar_t resp_scalar_o
);

  // Bits in one lane slice
  localparam int unsigned lane_bits = $bits(vec_pkg::lane_vec_t);

  // The combiner has exactly two lane inputs
  if (`VEC_NR_LANES != 2) begin : gen_lane_guard
    $error("vec_unit is built for exactly two lanes");
  end

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  // Only entry 0 of valid and op feeds the combiner
  logic                lane_valid   [`VEC_NR_LANES];
  vec_pkg::vop_e       lane_op      [`VEC_NR_LANES];
  vec_pkg::lane_vec_t  lane_res     [`VEC_NR_LANES];
  vec_pkg::lane_mask_t lane_mask    [`VEC_NR_LANES];
  vec_pkg::scalar_t    lane_partial [`VEC_NR_LANES];

  // Lane l takes elements 2l and 2l+1
  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i    (clk_i                                 ),
      .rst_i    (rst_i                                 ),
      .valid_i  (req_valid_i                           ),
      .op_i     (req_op_i                              ),
      .vs1_i    (req_vs1_i[l*lane_bits +: lane_bits]   ),
      .vs2_i    (req_vs2_i[l*lane_bits +: lane_bits]   ),
      .valid_o  (lane_valid[l]                         ),
      .op_o     (lane_op[l]                            ),
      .res_o    (lane_res[l]                           ),
      .mask_o   (lane_mask[l]                          ),
      .partial_o(lane_partial[l]                       )
    );
  end

  //////////////////////////////////////////////////
  // Combiner
  //////////////////////////////////////////////////

  vec_combine i_combine (
    .clk_i          (clk_i          ),
    .rst_i          (rst_i          ),
    .valid_i        (lane_valid[0]  ),
    .op_i           (lane_op[0]     ),
    .lane0_res_i    (lane_res[0]    ),
    .lane1_res_i    (lane_res[1]    ),
    .lane0_mask_i   (lane_mask[0]   ),
    .lane1_mask_i   (lane_mask[1]   ),
    .lane0_partial_i(lane_partial[0]),
    .lane1_partial_i(lane_partial[1]),
    .valid_o        (resp_valid_o   ),
    .vec_o          (resp_vec_o     ),
    .mask_o         (resp_mask_o    ),
    .scalar_o       (resp_scalar_o  )
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the vec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f files.f --top-module vec_unit_tb -o vec_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/vec_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
